// File: src/accel_pkg.sv
package accel_pkg;

   // -------------------------------------------------------------------------
   // Widths that carry a meaning
   // -------------------------------------------------------------------------

   // CPU or host bus address
   typedef logic [15:0] addr_t;
   // Data byte
   typedef logic [7:0]  data_t;
   // Upper address byte
   typedef logic [7:0]  page_t;
   // Clock divider count and speed setting
   typedef logic [5:0]  div_t;
   // Slowdown counter after an addressable latch write
   typedef logic [3:0]  slow_t;

   // -------------------------------------------------------------------------
   // Timing and memory map constants
   // -------------------------------------------------------------------------

   // Phi0 delay chain length and the tap that drives Phi1/Phi2
   localparam int NPHI0_REGS = 6;
   localparam int PHIOUT_TAP = 1;

   // ROM slot holding BASIC on a Model B/B+
   localparam int BASIC_ROM = 15;

   // Latches, matched on bits 15..2
   localparam addr_t ROM_LATCH_ADDR    = 16'hFE30;
   localparam addr_t SHADOW_LATCH_ADDR = 16'hFE34;
   localparam addr_t SPEED_LATCH_ADDR  = 16'hFE38;
   // Addressable latch (sound and keyboard), matched in full
   localparam addr_t SOUND_LATCH_ADDR  = 16'hFE40;

   // Page bounds of the host memory map
   localparam page_t SCREEN_LO_PAGE = 8'h30;
   localparam page_t ROM_LO_PAGE    = 8'h80;
   localparam page_t VDU_LO_PAGE    = 8'hC0;
   localparam page_t IO_LO_PAGE     = 8'hFC;
   localparam page_t IO_HI_PAGE     = 8'hFF;

   // Slowdown reload values, in host bus cycles
   localparam slow_t SLOW_LONG  = 4'd15;
   localparam slow_t SLOW_SHORT = 4'd1;

   // Values left on the host bus between external cycles
   localparam addr_t IDLE_ADDR = 16'hFFFF;
   localparam data_t IDLE_DATA = 8'hFF;

endpackage

// File: src/cpu_access_if.sv
`timescale 1ns/1ps

interface cpu_access_if;
   import accel_pkg::*;

   // Access accepted at the last clock enable
   addr_t cur_addr;
   logic  cur_we;
   data_t cur_dout;
   // Verdict for cur_addr, fast RAM when set
   logic  is_internal;
   // Next access writes the fast RAM
   logic  ram_we;
   // Core clock enable
   logic  clken;

   // Decoder owns the access registers
   modport mem_side (output cur_addr, cur_we, cur_dout, is_internal, ram_we,
                     input clken);

   // Bus controller consumes the access and produces the enable
   modport bus_side (input cur_addr, cur_we, cur_dout, is_internal,
                     output clken);

   // RAM only needs its write strobe and the enable
   modport ram_side (input ram_we, clken);

endinterface

// File: src/phase_sync.sv
`timescale 1ns/1ps

module phase_sync (
   input  logic            cpu_clk,
   input  logic            rst_n,
   input  logic            phi_in,
   input  logic            res_n_in,
   input  logic            irq_n_in,
   input  logic            nmi_n_in,
   input  logic            rdy_in,
   input  logic            speed_wr,
   input  accel_pkg::div_t speed_val,
   output logic            phi1_out,
   output logic            phi2_out,
   output logic            tick,
   output logic            phi2_rise,
   output logic            phi2_fall,
   output logic            ext_cycle_end,
   output logic            cpu_reset,
   output logic            cpu_irq,
   output logic            cpu_nmi
);
   import accel_pkg::*;

   logic [NPHI0_REGS-1:0] phi0_r;
   logic [2:0]            sync_meta;
   logic [2:0]            sync_out;
   div_t                  clk_div;
   div_t                  cpu_div;

   // -------------------------------------------------------------------------
   // Phi0 delay chain and host phase outputs
   // -------------------------------------------------------------------------

   // Bit 0 is the newest sample
   always_ff @(posedge cpu_clk or negedge rst_n) begin
      if (!rst_n) begin
         phi0_r        <= '0;
         ext_cycle_end <= 1'b0;
      end else begin
         phi0_r        <= {phi0_r[NPHI0_REGS-2:0], phi_in};
         // Falling edge at the chain end, one cycle later
         ext_cycle_end <= phi0_r[NPHI0_REGS-1] & ~phi0_r[NPHI0_REGS-2];
      end
   end

   assign phi2_out = phi0_r[PHIOUT_TAP];
   assign phi1_out = ~phi0_r[PHIOUT_TAP];

   // Edges of the delayed Phi2, one stage behind the tap
   assign phi2_rise = phi0_r[PHIOUT_TAP] & ~phi0_r[PHIOUT_TAP+1];
   assign phi2_fall = ~phi0_r[PHIOUT_TAP] & phi0_r[PHIOUT_TAP+1];

   // Two-stage sync, inverted to active high for the core
   // Core is held in reset while the controller is
   always_ff @(posedge cpu_clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_meta <= 3'b100;
         sync_out  <= 3'b100;
      end else begin
         sync_meta <= {~res_n_in, ~irq_n_in, ~nmi_n_in};
         sync_out  <= sync_meta;
      end
   end

   assign {cpu_reset, cpu_irq, cpu_nmi} = sync_out;

   // -------------------------------------------------------------------------
   // Clock-enable divider
   // -------------------------------------------------------------------------

   // Speed latch value v gives a tick every v cycles, 0 means 64
   always_ff @(posedge cpu_clk or negedge rst_n) begin
      if (!rst_n) begin
         cpu_div <= '0;
         clk_div <= '0;
         tick    <= 1'b0;
      end else begin
         if (speed_wr)
            cpu_div <= speed_val - div_t'(1);
         // Restart while the host stalls so the first cycle after Rdy is a tick
         if (!rdy_in || clk_div == cpu_div)
            clk_div <= '0;
         else
            clk_div <= clk_div + div_t'(1);
         tick <= (clk_div == '0);
      end
   end

   // Bus cycle end and data sample never collide
   a_end_vs_fall : assert property (@(posedge cpu_clk) disable iff (!rst_n)
      !(ext_cycle_end && phi2_fall));

endmodule

// File: src/memory_map.sv
`timescale 1ns/1ps

module memory_map (
   input  logic             cpu_clk,
   input  logic             rst_n,
   input  accel_pkg::addr_t cpu_addr_next,
   input  logic             cpu_we_next,
   input  logic             cpu_sync,
   input  accel_pkg::data_t cpu_dout_next,
   cpu_access_if.mem_side   acc,
   output logic             speed_wr,
   output accel_pkg::div_t  speed_val
);
   import accel_pkg::*;

   page_t page;
   logic  rom_latch_basic;
   logic  shadow;
   logic  vdu_op;
   logic  is_rom_latch;
   logic  is_shadow_latch;
   logic  is_speed_latch;
   logic  is_shadow_latch_next;
   logic  is_speed_latch_next;
   logic  screen_wr_ext;
   logic  screen_rd_ext;
   logic  fsb_wren;
   logic  in_screen;
   logic  in_rom;
   logic  in_io;
   logic  is_internal_next;

   // -------------------------------------------------------------------------
   // Registered access and latches
   // -------------------------------------------------------------------------

   // Latch decode on the access being completed
   assign is_rom_latch    = acc.cur_addr[15:2] == ROM_LATCH_ADDR[15:2];
   assign is_shadow_latch = acc.cur_addr[15:2] == SHADOW_LATCH_ADDR[15:2];
   assign is_speed_latch  = acc.cur_addr[15:2] == SPEED_LATCH_ADDR[15:2];

   always_ff @(posedge cpu_clk or negedge rst_n) begin
      if (!rst_n) begin
         acc.cur_addr    <= IDLE_ADDR;
         acc.cur_we      <= 1'b0;
         acc.cur_dout    <= IDLE_DATA;
         // First access after reset is taken at full speed
         acc.is_internal <= 1'b1;
         rom_latch_basic <= 1'b0;
         shadow          <= 1'b0;
         vdu_op          <= 1'b0;
      end else if (acc.clken) begin
         acc.cur_addr    <= cpu_addr_next;
         acc.cur_we      <= cpu_we_next;
         acc.cur_dout    <= cpu_dout_next;
         acc.is_internal <= is_internal_next;
         // FE30 ROM select, only BASIC is held internally
         if (acc.cur_we && is_rom_latch)
            rom_latch_basic <= acc.cur_dout[3:0] == 4'(BASIC_ROM);
         // FE34 bit 7 selects the B+ shadow screen
         if (acc.cur_we && is_shadow_latch)
            shadow <= acc.cur_dout[7];
         // Opcode fetch from C000-DFFF means VDU driver code
         if (cpu_sync)
            vdu_op <= cpu_addr_next[15:13] == VDU_LO_PAGE[7:5];
      end
   end

   // FE38 speed value, the divider keeps it
   assign speed_wr  = acc.clken & acc.cur_we & is_speed_latch;
   assign speed_val = acc.cur_dout[5:0];

   // -------------------------------------------------------------------------
   // Lookahead decode of the next access
   // -------------------------------------------------------------------------

   // B+ shadow policy, display always comes from the host main bank
   // Shadow off  mirror the main bank, slow writes and fast reads
   // Shadow on   VDU code goes to the host, other code uses fast RAM
   assign screen_wr_ext = shadow ? vdu_op : 1'b1;
   assign screen_rd_ext = shadow ? vdu_op : 1'b0;
   assign fsb_wren      = shadow ? ~vdu_op : 1'b1;

   assign page = cpu_addr_next[15:8];

   assign in_screen = page >= SCREEN_LO_PAGE && page < ROM_LO_PAGE;
   assign in_rom    = page >= ROM_LO_PAGE && page < VDU_LO_PAGE;
   // FF page holds the MOS vectors and stays fast
   assign in_io     = page >= IO_LO_PAGE && page < IO_HI_PAGE;

   assign is_shadow_latch_next = cpu_addr_next[15:2] == SHADOW_LATCH_ADDR[15:2];
   assign is_speed_latch_next  = cpu_addr_next[15:2] == SPEED_LATCH_ADDR[15:2];

   // Shadow and speed latches stay local so the host ROM select is untouched
   assign is_internal_next =
      !((in_screen && (cpu_we_next ? screen_wr_ext : screen_rd_ext)) ||
        (in_rom && !rom_latch_basic) ||
        in_io) ||
      is_shadow_latch_next || is_speed_latch_next;

   // Fast RAM covers 0000-7FFF, screen pages only when the policy allows
   assign acc.ram_we = cpu_we_next && !cpu_addr_next[15] &&
                       (page < SCREEN_LO_PAGE || fsb_wren);

   // ROM and IO images are never overwritten in fast RAM
   a_ram_we_low : assert property (@(posedge cpu_clk) disable iff (!rst_n)
      (acc.ram_we && acc.clken) |=> (acc.cur_addr < {ROM_LO_PAGE, 8'h00}));

endmodule

// File: src/fast_ram.sv
`timescale 1ns/1ps

module fast_ram (
   input  logic             cpu_clk,
   input  accel_pkg::addr_t cpu_addr_next,
   input  accel_pkg::data_t cpu_dout_next,
   cpu_access_if.ram_side   acc,
   output accel_pkg::data_t ram_dout
);
   import accel_pkg::*;

   // Full 64K map, upper half is never written
   localparam int RAM_DEPTH = 2 ** $bits(addr_t);

   data_t mem [RAM_DEPTH];

   // -------------------------------------------------------------------------
   // Synchronous port, advances with the core
   // -------------------------------------------------------------------------

   // Address is the lookahead one, so data is ready at the next enable
   always_ff @(posedge cpu_clk) begin
      if (acc.clken) begin
         if (acc.ram_we)
            mem[cpu_addr_next] <= cpu_dout_next;
         // Read returns the old contents on a write cycle
         ram_dout <= mem[cpu_addr_next];
      end
   end

endmodule

// File: src/ext_bus_ctrl.sv
`timescale 1ns/1ps

module ext_bus_ctrl (
   input  logic             cpu_clk,
   input  logic             rst_n,
   input  logic             phi_in,
   input  logic             rdy_in,
   input  logic             tick,
   input  logic             phi2_rise,
   input  logic             phi2_fall,
   input  logic             ext_cycle_end,
   input  accel_pkg::data_t ram_dout,
   input  accel_pkg::data_t bus_din,
   cpu_access_if.bus_side   acc,
   output logic             cpu_clken,
   output accel_pkg::data_t cpu_din,
   output accel_pkg::data_t bus_dout,
   output accel_pkg::addr_t bus_addr,
   output logic             bus_we,
   output logic             bus_dout_en
);
   import accel_pkg::*;

   logic  ext_busy;
   logic  ext_cycle_start;
   logic  rdy_s;
   slow_t slow_cnt;
   data_t data_r;

   // -------------------------------------------------------------------------
   // Host bus cycle
   // -------------------------------------------------------------------------

   // Bus changes a cycle after the chain end, for address hold time
   always_ff @(posedge cpu_clk or negedge rst_n) begin
      if (!rst_n) begin
         ext_cycle_start <= 1'b0;
         ext_busy        <= 1'b0;
         bus_addr        <= IDLE_ADDR;
         bus_we          <= 1'b0;
         bus_dout        <= IDLE_DATA;
      end else begin
         ext_cycle_start <= ext_cycle_end;
         if (ext_cycle_start) begin
            if (acc.is_internal) begin
               bus_addr <= IDLE_ADDR;
               bus_we   <= 1'b0;
               bus_dout <= IDLE_DATA;
               ext_busy <= 1'b0;
            end else begin
               bus_addr <= acc.cur_addr;
               bus_we   <= acc.cur_we;
               bus_dout <= acc.cur_dout;
               ext_busy <= 1'b1;
            end
         end
      end
   end

   // Data only driven in Phi2 of a write
   assign bus_dout_en = bus_we & phi_in;

   // Read data sampled at the delayed Phi2 fall
   always_ff @(posedge cpu_clk) begin
      if (phi2_fall)
         data_r <= bus_din;
   end

   // -------------------------------------------------------------------------
   // Rdy, slowdown and the clock enable
   // -------------------------------------------------------------------------

   // Keyboard and sound chip need the latch held for several bus cycles
   // Sound gets about 15 cycles of 500 ns, keyboard just one
   always_ff @(posedge cpu_clk or negedge rst_n) begin
      if (!rst_n) begin
         rdy_s    <= 1'b1;
         slow_cnt <= '0;
      end else begin
         // Rdy sampled mid cycle, as a 6502 does
         if (phi2_rise)
            rdy_s <= rdy_in;
         if (ext_cycle_end) begin
            if (acc.cur_we && acc.cur_addr == SOUND_LATCH_ADDR)
               slow_cnt <= (acc.cur_dout[2:0] == 3'b000) ? SLOW_LONG : SLOW_SHORT;
            else if (slow_cnt != '0)
               slow_cnt <= slow_cnt - slow_t'(1);
         end
      end
   end

   // Fast access on a divider tick, slow access at the host cycle end
   // Rdy low holds off both
   assign cpu_clken = rdy_s &&
                      ((acc.is_internal && tick && slow_cnt == '0) ||
                       (ext_busy && ext_cycle_end));
   assign acc.clken = cpu_clken;

   assign cpu_din = acc.is_internal ? ram_dout : data_r;

   // Slowdown must stall fast accesses too
   a_slow_holds : assert property (@(posedge cpu_clk) disable iff (!rst_n)
      cpu_clken |-> !(acc.is_internal && slow_cnt != '0));

endmodule

// File: src/accel_top.sv
`timescale 1ns/1ps

module accel_top (
   input  logic             cpu_clk,
   input  logic             rst_n,
   input  logic             phi_in,
   input  logic             res_n,
   input  logic             irq_n,
   input  logic             nmi_n,
   input  logic             rdy,
   input  logic             cpu_we_next,
   input  logic             cpu_sync,
   input  accel_pkg::addr_t cpu_addr_next,
   input  accel_pkg::data_t cpu_dout_next,
   input  accel_pkg::data_t bus_din,
   output logic             phi1_out,
   output logic             phi2_out,
   output logic             cpu_clken,
   output logic             cpu_reset,
   output logic             cpu_irq,
   output logic             cpu_nmi,
   output logic             bus_we,
   output logic             bus_dout_en,
   output accel_pkg::data_t cpu_din,
   output accel_pkg::data_t bus_dout,
   output accel_pkg::addr_t bus_addr
);
   import accel_pkg::*;

   logic  tick;
   logic  phi2_rise;
   logic  phi2_fall;
   logic  ext_cycle_end;
   logic  speed_wr;
   div_t  speed_val;
   data_t ram_dout;

   // Registered access shared by decoder, RAM and bus controller
   cpu_access_if acc_if ();

   // Host clock phases, input syncs and divider
   phase_sync phase_sync_inst (
      .cpu_clk       (cpu_clk),
      .rst_n         (rst_n),
      .phi_in        (phi_in),
      .res_n_in      (res_n),
      .irq_n_in      (irq_n),
      .nmi_n_in      (nmi_n),
      .rdy_in        (rdy),
      .speed_wr      (speed_wr),
      .speed_val     (speed_val),
      .phi1_out      (phi1_out),
      .phi2_out      (phi2_out),
      .tick          (tick),
      .phi2_rise     (phi2_rise),
      .phi2_fall     (phi2_fall),
      .ext_cycle_end (ext_cycle_end),
      .cpu_reset     (cpu_reset),
      .cpu_irq       (cpu_irq),
      .cpu_nmi       (cpu_nmi)
   );

   memory_map memory_map_inst (
      .cpu_clk       (cpu_clk),
      .rst_n         (rst_n),
      .cpu_addr_next (cpu_addr_next),
      .cpu_we_next   (cpu_we_next),
      .cpu_sync      (cpu_sync),
      .cpu_dout_next (cpu_dout_next),
      .acc           (acc_if.mem_side),
      .speed_wr      (speed_wr),
      .speed_val     (speed_val)
   );

   fast_ram fast_ram_inst (
      .cpu_clk       (cpu_clk),
      .cpu_addr_next (cpu_addr_next),
      .cpu_dout_next (cpu_dout_next),
      .acc           (acc_if.ram_side),
      .ram_dout      (ram_dout)
   );

   // Host bus side and core clock enable
   ext_bus_ctrl ext_bus_ctrl_inst (
      .cpu_clk       (cpu_clk),
      .rst_n         (rst_n),
      .phi_in        (phi_in),
      .rdy_in        (rdy),
      .tick          (tick),
      .phi2_rise     (phi2_rise),
      .phi2_fall     (phi2_fall),
      .ext_cycle_end (ext_cycle_end),
      .ram_dout      (ram_dout),
      .bus_din       (bus_din),
      .acc           (acc_if.bus_side),
      .cpu_clken     (cpu_clken),
      .cpu_din       (cpu_din),
      .bus_dout      (bus_dout),
      .bus_addr      (bus_addr),
      .bus_we        (bus_we),
      .bus_dout_en   (bus_dout_en)
   );

endmodule

// File: dv/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;
   import accel_pkg::*;

   localparam int CLK_PERIOD  = 4;
   localparam int PHI0_CYCLES = 32;
   localparam int NUM_TESTS   = 7;
   // Read filler that keeps the core busy while nothing else is pending
   localparam addr_t PARK_ADDR = 16'h0100;

   logic  cpu_clk   = 1'b0;
   logic  rst_n     = 1'b0;
   logic  phi_in    = 1'b1;
   logic  res_n     = 1'b1;
   logic  irq_n     = 1'b1;
   logic  nmi_n     = 1'b1;
   logic  rdy       = 1'b1;
   logic  cpu_we_next;
   logic  cpu_sync;
   addr_t cpu_addr_next;
   data_t cpu_dout_next;
   data_t bus_din   = IDLE_DATA;
   logic  phi1_out;
   logic  phi2_out;
   logic  cpu_clken;
   logic  cpu_reset;
   logic  cpu_irq;
   logic  cpu_nmi;
   logic  bus_we;
   logic  bus_dout_en;
   data_t cpu_din;
   data_t bus_dout;
   addr_t bus_addr;

   int    phase      = 0;
   int    phi_falls  = 0;
   int    bus_cycles = 0;
   int    cycle_cnt  = 0;
   int    checks     = 0;
   int    errors     = 0;
   string test_name;
   addr_t wr_addr_log[$];
   data_t wr_data_log[$];

   accel_top accel_top_inst (
      .cpu_clk       (cpu_clk),
      .rst_n         (rst_n),
      .phi_in        (phi_in),
      .res_n         (res_n),
      .irq_n         (irq_n),
      .nmi_n         (nmi_n),
      .rdy           (rdy),
      .cpu_we_next   (cpu_we_next),
      .cpu_sync      (cpu_sync),
      .cpu_addr_next (cpu_addr_next),
      .cpu_dout_next (cpu_dout_next),
      .bus_din       (bus_din),
      .phi1_out      (phi1_out),
      .phi2_out      (phi2_out),
      .cpu_clken     (cpu_clken),
      .cpu_reset     (cpu_reset),
      .cpu_irq       (cpu_irq),
      .cpu_nmi       (cpu_nmi),
      .bus_we        (bus_we),
      .bus_dout_en   (bus_dout_en),
      .cpu_din       (cpu_din),
      .bus_dout      (bus_dout),
      .bus_addr      (bus_addr)
   );

   always #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;

   always @(posedge cpu_clk) cycle_cnt <= cycle_cnt + 1;

   // ---------------------------------------------------------------------------
   // Host bus model
   // ---------------------------------------------------------------------------

   // Phi0 high for phases 0..15, low for 16..31
   always @(negedge cpu_clk) begin
      if (phase == PHI0_CYCLES - 1) begin
         phase  <= 0;
         phi_in <= 1'b1;
      end else begin
         phase <= phase + 1;
         if (phase + 1 == PHI0_CYCLES / 2) begin
            phi_in    <= 1'b0;
            phi_falls <= phi_falls + 1;
         end
      end
      // Host returns the address low byte XOR A5
      bus_din <= bus_addr[7:0] ^ 8'hA5;
      // Bus holds one cycle per Phi0 period, sample mid high phase
      if (phase == 8) begin
         if (bus_addr != IDLE_ADDR)
            bus_cycles <= bus_cycles + 1;
         if (bus_we) begin
            wr_addr_log.push_back(bus_addr);
            wr_data_log.push_back(bus_dout);
            // Write data is driven while Phi0 is high
            check_value(1, bus_dout_en);
         end
      end
      // Data bus released while Phi0 is low
      if (phase == 24)
         check_value(0, bus_dout_en);
   end

   // Bound on the whole run, 200 Phi0 periods per test
   initial begin
      #(NUM_TESTS * 200 * PHI0_CYCLES * CLK_PERIOD);
      $display("Timeout: cpu_clken stopped arriving, run aborted during %s", test_name);
      $display("Checks failed");
      $finish;
   end

   // ---------------------------------------------------------------------------
   // Core model and checks
   // ---------------------------------------------------------------------------

   task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
      end
   endtask

   // Polls the synchronised core pins, gives up after a few cycles
   task automatic expect_core_pins(input logic [2:0] expected);
      int n;
      n = 0;
      while ({cpu_reset, cpu_irq, cpu_nmi} !== expected && n < 8) begin
         @(negedge cpu_clk);
         n++;
      end
      check_value(32'(expected), 32'({cpu_reset, cpu_irq, cpu_nmi}));
   endtask

   task automatic park_cpu();
      cpu_addr_next = PARK_ADDR;
      cpu_we_next   = 1'b0;
      cpu_dout_next = 8'h00;
      cpu_sync      = 1'b0;
   endtask

   task automatic wait_clken();
      while (!cpu_clken)
         @(negedge cpu_clk);
   endtask

   // Entered on a falling edge, returns on one with the filler accepted
   task automatic cpu_access(input addr_t addr, input logic we, input data_t wdata,
                             input logic sync, output data_t rdata);
      cpu_addr_next = addr;
      cpu_we_next   = we;
      cpu_dout_next = wdata;
      cpu_sync      = sync;
      // Accepted at the rising edge after this enable
      wait_clken();
      @(negedge cpu_clk);
      park_cpu();
      // Next enable ends the access and carries its read data
      wait_clken();
      rdata = cpu_din;
      @(negedge cpu_clk);
   endtask

   task automatic cpu_write(input addr_t addr, input data_t wdata);
      data_t unused;
      cpu_access(addr, 1'b1, wdata, 1'b0, unused);
   endtask

   task automatic cpu_read(input addr_t addr, output data_t rdata);
      cpu_access(addr, 1'b0, 8'h00, 1'b0, rdata);
   endtask

   // ---------------------------------------------------------------------------
   // Directed tests
   // ---------------------------------------------------------------------------

   // Control outputs idle while the controller is held in reset
   task automatic reset_outputs();
      test_name = "reset";
      check_value(0, cpu_clken);
      check_value(0, bus_we);
      check_value(0, bus_dout_en);
      check_value(32'(IDLE_ADDR), 32'(bus_addr));
      check_value(32'(3'b100), 32'({cpu_reset, cpu_irq, cpu_nmi}));
   endtask

   task automatic host_pins();
      test_name = "host_pins";
      // Mid high and mid low of Phi0, well past the chain delay
      while (phase != 8)
         @(negedge cpu_clk);
      check_value(1, phi2_out);
      check_value(0, phi1_out);
      while (phase != 24)
         @(negedge cpu_clk);
      check_value(0, phi2_out);
      check_value(1, phi1_out);
      // One host line at a time, so a swapped pin shows up
      irq_n = 1'b0;
      expect_core_pins(3'b010);
      irq_n = 1'b1;
      nmi_n = 1'b0;
      expect_core_pins(3'b001);
      nmi_n = 1'b1;
      res_n = 1'b0;
      expect_core_pins(3'b100);
      res_n = 1'b1;
      expect_core_pins(3'b000);
   endtask

   task automatic ram_readback();
      addr_t addr_list[8];
      data_t data_list[8];
      data_t rdata;
      int    cycles0;
      test_name = "internal_ram";
      cycles0   = bus_cycles;
      for (int i = 0; i < 8; i++) begin
         // Distinct pages 00 to 2A, below the screen
         addr_list[i] = {8'(i * 6), 8'($urandom)};
         data_list[i] = 8'($urandom);
         cpu_write(addr_list[i], data_list[i]);
         check_value(32'(IDLE_ADDR), 32'(bus_addr));
      end
      for (int i = 0; i < 8; i++) begin
         cpu_read(addr_list[i], rdata);
         check_value(32'(data_list[i]), 32'(rdata));
         check_value(32'(IDLE_ADDR), 32'(bus_addr));
      end
      check_value(cycles0, bus_cycles);
   endtask

   task automatic io_bus_access();
      data_t wdata;
      data_t rdata;
      int    n0;
      test_name = "external_io";
      wdata     = 8'($urandom);
      n0        = wr_addr_log.size();
      cpu_write(16'hFE60, wdata);
      check_value(n0 + 1, wr_addr_log.size());
      if (wr_addr_log.size() > n0) begin
         check_value(32'hFE60, 32'(wr_addr_log[$]));
         check_value(32'(wdata), 32'(wr_data_log[$]));
      end
      cpu_read(16'hFC10, rdata);
      check_value(32'(8'h10 ^ 8'hA5), 32'(rdata));
      // A read never strobes bus_we
      check_value(n0 + 1, wr_addr_log.size());
   endtask

   task automatic rom_select();
      data_t rdata;
      int    n0;
      // Sideways ROM 3 lives on the host
      test_name = "rom_latch_3";
      cpu_write(16'hFE30, 8'd3);
      n0 = bus_cycles;
      cpu_read(16'h8000, rdata);
      check_value(n0 + 1, bus_cycles);
      // BASIC is served from fast RAM
      test_name = "rom_latch_15";
      cpu_write(16'hFE30, 8'd15);
      n0 = bus_cycles;
      cpu_read(16'h8000, rdata);
      check_value(n0, bus_cycles);
   endtask

   task automatic shadow_screen();
      data_t b1;
      data_t b2;
      data_t rdata;
      int    n0;
      test_name = "shadow_off";
      b1 = 8'($urandom);
      // Write goes out and is mirrored, read stays local
      n0 = bus_cycles;
      cpu_write(16'h3000, b1);
      check_value(n0 + 1, bus_cycles);
      n0 = bus_cycles;
      cpu_read(16'h3000, rdata);
      check_value(32'(b1), 32'(rdata));
      check_value(n0, bus_cycles);
      test_name = "shadow_on";
      cpu_write(16'hFE34, 8'h80);
      // VDU driver fetch first, so the later fetches have to clear it
      cpu_access(16'hC000, 1'b0, 8'h00, 1'b1, rdata);
      // Opcode fetches outside the VDU driver
      cpu_access(16'h1000, 1'b0, 8'h00, 1'b1, rdata);
      cpu_access(16'h1001, 1'b0, 8'h00, 1'b1, rdata);
      // Inverted byte, so a stale mirror shows up
      b2 = ~b1;
      n0 = bus_cycles;
      cpu_write(16'h3000, b2);
      cpu_read(16'h3000, rdata);
      check_value(32'(b2), 32'(rdata));
      check_value(n0, bus_cycles);
      cpu_write(16'hFE34, 8'h00);
   endtask

   task automatic check_spacing(input int v);
      int stamps[7];
      int n;
      n         = 0;
      test_name = $sformatf("speed_latch v=%0d", v);
      // Filler stays on the inputs, so every enable is internal
      while (n < 7) begin
         @(negedge cpu_clk);
         if (cpu_clken) begin
            stamps[n] = cycle_cnt;
            n++;
         end
      end
      // First pulses may still follow the old divider count
      for (int i = 3; i < 7; i++)
         check_value(v, stamps[i] - stamps[i - 1]);
   endtask

   task automatic speed_divider();
      int speeds[3] = '{1, 4, 7};
      for (int i = 0; i < 3; i++) begin
         cpu_write(16'hFE38, 8'(speeds[i]));
         check_spacing(speeds[i]);
      end
      // Back to full speed
      cpu_write(16'hFE38, 8'd1);
   endtask

   task automatic sound_slowdown();
      int falls0;
      // Data bits 2..0 clear, long hold of 15 host cycles
      test_name = "slowdown_long";
      cpu_write(16'hFE40, 8'h00);
      falls0 = phi_falls;
      wait_clken();
      check_value(15, phi_falls - falls0);
      test_name = "slowdown_short";
      cpu_write(16'hFE40, 8'h01);
      falls0 = phi_falls;
      wait_clken();
      check_value(1, phi_falls - falls0);
   endtask

   initial begin
      void'($urandom(83));
      park_cpu();
      test_name = "reset";
      repeat (4) @(negedge cpu_clk);
      reset_outputs();
      rst_n = 1'b1;
      host_pins();
      ram_readback();
      io_bus_access();
      rom_select();
      shadow_screen();
      speed_divider();
      sound_slowdown();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: build.f
src/accel_pkg.sv
src/cpu_access_if.sv
src/phase_sync.sv
src/memory_map.sv
src/fast_ram.sv
src/ext_bus_ctrl.sv
src/accel_top.sv
dv/tb_accel.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_accel \
   -f build.f -Mdir "$BUILD_DIR" -o tb_accel
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_accel" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All checks passed" "$LOG"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1
